// File: Makefile
# Verilator build and run for the n64_loader front end

VERILATOR  ?= verilator
TOP        ?= tb_n64_loader
RTL_TOP    ?= n64_loader_top
FILELIST   ?= n64_loader.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: n64_loader.f
src/n64_loader_pkg.sv
src/download_packer.sv
src/cart_write_port.sv
src/backup_control.sv
src/n64_loader_top.sv
verification/n64_loader_checker.sv
verification/tb_n64_loader.sv

// File: src/backup_control.sv
// Backup save control
// Registers the load and save requests for the save memory, tracks
// whether a writable save image is mounted for the current cartridge,
// and decodes the EEPROM type from the save-type setting.

`timescale 1ns/1ps

module backup_control (
	input  logic clk_1x,
	input  logic rst_n,
	input  logic cart_download,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic [31:0] img_size,
	input  logic osd_reload,
	input  logic osd_save,
	input  logic osd_open,
	input  logic autosave_off,
	input  n64_loader_pkg::save_type_e save_type,
	output logic bk_load,
	output logic bk_save,
	output logic use_img,
	output n64_loader_pkg::eeprom_type_e eeprom_type
);

	logic download_d;
	logic download_start;
	logic img_writable;

	assign download_start = cart_download & ~download_d;
	assign img_writable = img_mounted & (img_size != 32'd0) & ~img_readonly;

	// ========================================
	// Requests and image tracking
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			bk_load <= 1'b0;
			bk_save <= 1'b0;
			use_img <= 1'b0;
			download_d <= 1'b0;
		end else begin
			// Reload on menu request or when a new cart comes with an image
			bk_load <= osd_reload | (cart_download & img_mounted);
			// Opening the OSD triggers an autosave unless disabled
			bk_save <= osd_save | (osd_open & ~autosave_off);
			download_d <= cart_download;
			if (img_writable)
				use_img <= 1'b1;
			else if (download_start)
				use_img <= 1'b0;
		end
	end

	// EEPROM size
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			eeprom_type <= n64_loader_pkg::eeprom_none;
		end else begin
			case (save_type)
				n64_loader_pkg::eeprom4: eeprom_type <= n64_loader_pkg::eeprom_4k;
				n64_loader_pkg::eeprom16: eeprom_type <= n64_loader_pkg::eeprom_16k;
				default: eeprom_type <= n64_loader_pkg::eeprom_none;
			endcase
		end
	end

endmodule

// File: src/cart_write_port.sv
// Cartridge write port
// Takes one assembled cartridge word at a time, issues a single
// write request to SDRAM and stalls the host with ioctl_wait until
// the memory answers or the download is abandoned. Also remembers
// that a cartridge has been loaded since reset.

`timescale 1ns/1ps

module cart_write_port (
	input  logic clk_1x,
	input  logic rst_n,
	input  logic active,
	input  logic word_valid,
	input  n64_loader_pkg::ioctl_addr_t word_addr,
	input  n64_loader_pkg::word_t word_data,
	input  logic sdram_ready,
	output logic sdram_req,
	output n64_loader_pkg::ioctl_addr_t sdram_addr,
	output n64_loader_pkg::word_t sdram_din,
	output logic ioctl_wait,
	output logic cart_loaded
);

	logic issue;

	// A word only goes out while the download is still running
	assign issue = word_valid & active;

	// ========================================
	// Request and host stall
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			sdram_req <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			sdram_req <= issue;
			if (!active) begin
				// Download gone, release the host
				ioctl_wait <= 1'b0;
			end else if (issue) begin
				ioctl_wait <= 1'b1;
			end else if (sdram_ready) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Word and address stay put until the next issue
	always_ff @(posedge clk_1x) begin
		if (issue) begin
			sdram_addr <= word_addr;
			sdram_din <= word_data;
		end
	end

	// ========================================
	// Load status
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n)
			cart_loaded <= 1'b0;
		else if (active)
			cart_loaded <= 1'b1;
	end

endmodule

// File: src/download_packer.sv
// Download packer
// Watches the host ioctl stream for one download index and pairs
// 16-bit halves into addressed 32-bit words. The boot-ROM flavour
// swaps bytes and builds a word address; the cartridge flavour keeps
// byte order and offsets the byte address by the cartridge base.

`timescale 1ns/1ps

module download_packer #(
	parameter n64_loader_pkg::download_target_e target = n64_loader_pkg::target_pifrom,
	parameter type addr_t = n64_loader_pkg::pif_addr_t
) (
	input  logic clk_1x,
	input  logic rst_n,
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  n64_loader_pkg::ioctl_addr_t ioctl_addr,
	input  n64_loader_pkg::half_t ioctl_dout,
	input  logic ioctl_wr,
	output logic active,
	output logic word_valid,
	output addr_t word_addr,
	output n64_loader_pkg::word_t word_data
);

	// Index bits this instance answers to
	localparam logic [n64_loader_pkg::index_sel_w-1:0] my_sel =
		(target == n64_loader_pkg::target_pifrom) ?
		n64_loader_pkg::index_sel_w'(n64_loader_pkg::pif_index) :
		n64_loader_pkg::index_sel_w'(n64_loader_pkg::cart_index);

	localparam n64_loader_pkg::ioctl_addr_t cart_base =
		n64_loader_pkg::ioctl_addr_t'(n64_loader_pkg::cart_start);

	logic index_match;
	logic first_half;
	logic second_half;
	n64_loader_pkg::half_t dout_swapped;
	addr_t next_addr;

	assign index_match = (ioctl_index[n64_loader_pkg::index_sel_w-1:0] == my_sel);

	// Address bit 1 tells which half of the word is on the bus
	assign first_half = active & ioctl_wr & ~ioctl_addr[1];
	assign second_half = active & ioctl_wr & ioctl_addr[1];

	assign dout_swapped = {ioctl_dout[7:0], ioctl_dout[15:8]};

	always_comb begin
		if (target == n64_loader_pkg::target_pifrom) begin
			// Index bit 6 picks the upper half of the boot ROM
			next_addr = addr_t'({ioctl_index[6], ioctl_addr[10:2]});
		end else begin
			next_addr = addr_t'(ioctl_addr + cart_base);
		end
	end

	// ========================================
	// Control
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			active <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			active <= ioctl_download & index_match;
			word_valid <= second_half;
		end
	end

	// Word assembly
	always_ff @(posedge clk_1x) begin
		if (first_half) begin
			word_addr <= next_addr;
			if (target == n64_loader_pkg::target_pifrom)
				word_data[31:16] <= dout_swapped;
			else
				word_data[15:0] <= ioctl_dout;
		end
		if (second_half) begin
			if (target == n64_loader_pkg::target_pifrom)
				word_data[15:0] <= dout_swapped;
			else
				word_data[31:16] <= ioctl_dout;
		end
	end

endmodule

// File: src/n64_loader_pkg.sv
// Shared definitions for the N64 loader front end
// Widths, download indices, the cartridge base address in SDRAM,
// and the enumerated types used by the packers and the backup block

package n64_loader_pkg;

	// ========================================
	// Widths
	// ========================================
	localparam int ioctl_addr_w = 27;
	localparam int half_w = 16;
	localparam int word_w = 32;
	localparam int pif_addr_w = 10;

	// Low index bits that select a download target
	localparam int index_sel_w = 6;

	// ========================================
	// Download indices and base address
	// ========================================
	localparam int pif_index = 0;
	localparam int cart_index = 1;

	// Cartridge image sits at 8 MiB in SDRAM
	localparam int unsigned cart_start = 8388608;

	// ========================================
	// Types
	// ========================================
	typedef logic [ioctl_addr_w-1:0] ioctl_addr_t;
	typedef logic [half_w-1:0] half_t;
	typedef logic [word_w-1:0] word_t;
	typedef logic [pif_addr_w-1:0] pif_addr_t;

	typedef enum logic {
		target_pifrom,
		target_cart
	} download_target_e;

	// Save setting from the OSD menu
	typedef enum logic [2:0] {
		none = 3'd0,
		eeprom4 = 3'd1,
		eeprom16 = 3'd2,
		sram32 = 3'd3,
		sram96 = 3'd4,
		flash = 3'd5
	} save_type_e;

	typedef enum logic [1:0] {
		eeprom_none = 2'd0,
		eeprom_4k = 2'd1,
		eeprom_16k = 2'd2
	} eeprom_type_e;

endpackage

// File: src/n64_loader_top.sv
// N64 loader front end
// Host download paths for the boot ROM and the cartridge image,
// the SDRAM write port for cartridge words, and the backup-save
// request and EEPROM-type logic. Wiring only.

`timescale 1ns/1ps

module n64_loader_top (
	input  logic clk_1x,
	input  logic rst_n,

	// Host download port
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  n64_loader_pkg::ioctl_addr_t ioctl_addr,
	input  n64_loader_pkg::half_t ioctl_dout,
	input  logic ioctl_wr,
	output logic ioctl_wait,

	// Boot ROM write port
	output n64_loader_pkg::pif_addr_t pifrom_wraddress,
	output n64_loader_pkg::word_t pifrom_wrdata,
	output logic pifrom_wren,

	// SDRAM write channel
	output logic sdram_req,
	output n64_loader_pkg::ioctl_addr_t sdram_addr,
	output n64_loader_pkg::word_t sdram_din,
	input  logic sdram_ready,

	// Status
	output logic cart_download,
	output logic cart_loaded,

	// Backup save
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic [31:0] img_size,
	input  logic osd_reload,
	input  logic osd_save,
	input  logic osd_open,
	input  logic autosave_off,
	input  n64_loader_pkg::save_type_e save_type,
	output logic bk_load,
	output logic bk_save,
	output logic use_img,
	output n64_loader_pkg::eeprom_type_e eeprom_type
);

	logic cart_word_valid;
	n64_loader_pkg::ioctl_addr_t cart_word_addr;
	n64_loader_pkg::word_t cart_word_data;

	// ========================================
	// Boot ROM path
	// ========================================
	// Download flag of this path has no consumer
	download_packer #(
		.target (n64_loader_pkg::target_pifrom),
		.addr_t (n64_loader_pkg::pif_addr_t)
	) pif_packer (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.active         (),
		.word_valid     (pifrom_wren),
		.word_addr      (pifrom_wraddress),
		.word_data      (pifrom_wrdata)
	);

	// ========================================
	// Cartridge path
	// ========================================
	download_packer #(
		.target (n64_loader_pkg::target_cart),
		.addr_t (n64_loader_pkg::ioctl_addr_t)
	) cart_packer (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.active         (cart_download),
		.word_valid     (cart_word_valid),
		.word_addr      (cart_word_addr),
		.word_data      (cart_word_data)
	);

	cart_write_port cart_write_port_i (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.active      (cart_download),
		.word_valid  (cart_word_valid),
		.word_addr   (cart_word_addr),
		.word_data   (cart_word_data),
		.sdram_ready (sdram_ready),
		.sdram_req   (sdram_req),
		.sdram_addr  (sdram_addr),
		.sdram_din   (sdram_din),
		.ioctl_wait  (ioctl_wait),
		.cart_loaded (cart_loaded)
	);

	// Backup save
	backup_control backup_control_i (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.osd_reload    (osd_reload),
		.osd_save      (osd_save),
		.osd_open      (osd_open),
		.autosave_off  (autosave_off),
		.save_type     (save_type),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.use_img       (use_img),
		.eeprom_type   (eeprom_type)
	);

endmodule

// File: verification/n64_loader_checker.sv
// Handshake checker for the N64 loader front end
// Bound into the top level; watches the SDRAM request, the host
// stall and the boot-ROM write enable

`timescale 1ns/1ps

module n64_loader_checker (
	input logic clk_1x,
	input logic rst_n,
	input logic sdram_req,
	input logic ioctl_wait,
	input logic cart_download,
	input logic pifrom_wren
);

	// Request is a single-cycle pulse
	req_single_cycle: assert property (@(posedge clk_1x) disable iff (!rst_n)
		sdram_req |=> !sdram_req)
		else $error("sdram_req stayed high for two cycles");

	// Host is stalled while a request goes out
	wait_with_req: assert property (@(posedge clk_1x) disable iff (!rst_n)
		sdram_req |-> ioctl_wait)
		else $error("sdram_req high without ioctl_wait");

	// No stall outlives the cartridge download
	wait_needs_download: assert property (@(posedge clk_1x) disable iff (!rst_n)
		!cart_download |=> !ioctl_wait)
		else $error("ioctl_wait high after cart_download was low");

	no_overlap: assert property (@(posedge clk_1x) disable iff (!rst_n)
		!(pifrom_wren && sdram_req))
		else $error("pifrom_wren and sdram_req high together");

endmodule

bind n64_loader_top n64_loader_checker n64_loader_checker_i (
	.clk_1x        (clk_1x),
	.rst_n         (rst_n),
	.sdram_req     (sdram_req),
	.ioctl_wait    (ioctl_wait),
	.cart_download (cart_download),
	.pifrom_wren   (pifrom_wren)
);

// File: verification/tb_n64_loader.sv
// Testbench for the N64 loader front end
// Seeded random host downloads for both paths, a memory responder
// with random latency, and a queue model of the expected words.
// Also walks the backup-save requests, image use and EEPROM decode.

`timescale 1ns/1ps

module tb_n64_loader;

	localparam int boot_words = 8;
	localparam int cart_words = 16;
	localparam int filter_words = 4;
	localparam int total_writes = 2 * (2 * boot_words + cart_words + filter_words);
	localparam int margin_cycles = 400;

	logic clk_1x;
	logic rst_n;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	n64_loader_pkg::ioctl_addr_t ioctl_addr;
	n64_loader_pkg::half_t ioctl_dout;
	logic ioctl_wr;
	logic ioctl_wait;
	n64_loader_pkg::pif_addr_t pifrom_wraddress;
	n64_loader_pkg::word_t pifrom_wrdata;
	logic pifrom_wren;
	logic sdram_req;
	n64_loader_pkg::ioctl_addr_t sdram_addr;
	n64_loader_pkg::word_t sdram_din;
	logic sdram_ready;
	logic cart_download;
	logic cart_loaded;
	logic img_mounted;
	logic img_readonly;
	logic [31:0] img_size;
	logic osd_reload;
	logic osd_save;
	logic osd_open;
	logic autosave_off;
	n64_loader_pkg::save_type_e save_type;
	logic bk_load;
	logic bk_save;
	logic use_img;
	n64_loader_pkg::eeprom_type_e eeprom_type;

	integer seed = 32'hb0c8;
	int test_errors = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int total_errors = 0;
	int wren_count = 0;
	int req_count = 0;
	int wait_count = 0;
	logic [31:0] exp_addr[$];
	logic [31:0] exp_data[$];
	logic [31:0] got_addr[$];
	logic [31:0] got_data[$];

	n64_loader_top n64_loader_top_i (.*);

	initial begin
		clk_1x = 1'b0;
		forever #50 clk_1x = ~clk_1x;
	end

	// Capture every word that leaves either path
	always @(negedge clk_1x) begin
		if (pifrom_wren) begin
			got_addr.push_back(32'(pifrom_wraddress));
			got_data.push_back(pifrom_wrdata);
			wren_count++;
		end
		if (sdram_req) begin
			got_addr.push_back(32'(sdram_addr));
			got_data.push_back(sdram_din);
			req_count++;
		end
		if (ioctl_wait)
			wait_count++;
	end

	// SDRAM answers 0 to 7 cycles late
	initial begin : memory_responder
		int delay;
		forever begin
			@(negedge clk_1x);
			if (sdram_req) begin
				delay = $random(seed) & 7;
				repeat (delay) @(posedge clk_1x);
				@(posedge clk_1x);
				sdram_ready <= 1'b1;
				@(posedge clk_1x);
				sdram_ready <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (total_writes * 20 + margin_cycles) @(posedge clk_1x);
		$display("Watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	function automatic n64_loader_pkg::half_t swap_bytes(input n64_loader_pkg::half_t h);
		return {h[7:0], h[15:8]};
	endfunction

	function automatic logic [31:0] expected_eeprom(input int save);
		case (save)
			1: return 32'd1;
			2: return 32'd2;
			default: return 32'd0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errors);
			tests_bad++;
		end
		test_errors = 0;
	endtask

	// ========================================
	// Host side
	// ========================================
	task automatic start_download(input logic [7:0] index);
		@(posedge clk_1x);
		ioctl_index <= index;
		ioctl_download <= 1'b1;
		// First flagged cycle drops writes
		repeat (2) @(posedge clk_1x);
	endtask

	task automatic stop_download();
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_1x);
	endtask

	task automatic write_half(input n64_loader_pkg::ioctl_addr_t addr,
		input n64_loader_pkg::half_t data);
		@(posedge clk_1x);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
		@(posedge clk_1x);
		@(negedge clk_1x);
		while (ioctl_wait)
			@(negedge clk_1x);
	endtask

	task automatic send_word(input n64_loader_pkg::ioctl_addr_t addr,
		input n64_loader_pkg::half_t h0, input n64_loader_pkg::half_t h1);
		write_half(addr, h0);
		write_half(addr | 27'd2, h1);
	endtask

	task automatic run_boot_rom(input logic [7:0] index);
		n64_loader_pkg::ioctl_addr_t base;
		n64_loader_pkg::ioctl_addr_t addr;
		n64_loader_pkg::half_t h0;
		n64_loader_pkg::half_t h1;
		base = n64_loader_pkg::ioctl_addr_t'(($random(seed) & 32'h1ff) << 2);
		start_download(index);
		for (int k = 0; k < boot_words; k++) begin
			addr = base + n64_loader_pkg::ioctl_addr_t'(4 * k);
			h0 = n64_loader_pkg::half_t'($random(seed));
			h1 = n64_loader_pkg::half_t'($random(seed));
			exp_addr.push_back(32'({index[6], addr[10:2]}));
			exp_data.push_back({swap_bytes(h0), swap_bytes(h1)});
			send_word(addr, h0, h1);
		end
		stop_download();
	endtask

	task automatic run_cart();
		n64_loader_pkg::ioctl_addr_t base;
		n64_loader_pkg::ioctl_addr_t addr;
		n64_loader_pkg::half_t h0;
		n64_loader_pkg::half_t h1;
		base = n64_loader_pkg::ioctl_addr_t'(($random(seed) & 32'h7fffff) << 2);
		start_download(8'd1);
		@(negedge clk_1x);
		check_value("cart_download start", 32'd1, 32'(cart_download));
		for (int k = 0; k < cart_words; k++) begin
			addr = base + n64_loader_pkg::ioctl_addr_t'(4 * k);
			h0 = n64_loader_pkg::half_t'($random(seed));
			h1 = n64_loader_pkg::half_t'($random(seed));
			exp_addr.push_back(32'(n64_loader_pkg::ioctl_addr_t'(32'(addr) +
				n64_loader_pkg::cart_start)));
			exp_data.push_back({h1, h0});
			send_word(addr, h0, h1);
		end
		stop_download();
		@(negedge clk_1x);
		check_value("cart_download end", 32'd0, 32'(cart_download));
	endtask

	task automatic compare_words(input string name);
		check_value({name, " count"}, 32'(exp_data.size()), 32'(got_data.size()));
		while (exp_data.size() > 0 && got_data.size() > 0) begin
			check_value({name, " addr"}, exp_addr.pop_front(), got_addr.pop_front());
			check_value({name, " data"}, exp_data.pop_front(), got_data.pop_front());
		end
		exp_addr.delete();
		exp_data.delete();
		got_addr.delete();
		got_data.delete();
	endtask

	task automatic pulse_mount(input logic readonly, input logic [31:0] size);
		@(posedge clk_1x);
		img_mounted <= 1'b1;
		img_readonly <= readonly;
		img_size <= size;
		@(posedge clk_1x);
		img_mounted <= 1'b0;
		@(negedge clk_1x);
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin : main_sequence
		logic r_reload;
		logic r_save;
		logic r_open;
		logic r_auto;
		logic r_dl;
		logic r_mount;
		int wren_base;
		int req_base;
		int wait_base;
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		sdram_ready = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = 32'd0;
		osd_reload = 1'b0;
		osd_save = 1'b0;
		osd_open = 1'b0;
		autosave_off = 1'b0;
		save_type = n64_loader_pkg::none;
		repeat (8) @(posedge clk_1x);
		rst_n <= 1'b1;
		@(posedge clk_1x);

		run_boot_rom(8'd0);
		run_boot_rom(8'd64);
		compare_words("boot_rom_words");
		finish_test("boot_rom_words");

		run_cart();
		compare_words("cart_words");
		check_value("cart_loaded", 32'd1, 32'(cart_loaded));
		finish_test("cart_words");

		// Low index bits of 2 select neither path
		wren_base = wren_count;
		req_base = req_count;
		wait_base = wait_count;
		start_download(8'h82);
		for (int k = 0; k < filter_words; k++)
			send_word(n64_loader_pkg::ioctl_addr_t'(4 * k), 16'h1234, 16'h5678);
		stop_download();
		check_value("filter pifrom_wren", 32'd0, 32'(wren_count - wren_base));
		check_value("filter sdram_req", 32'd0, 32'(req_count - req_base));
		check_value("filter ioctl_wait", 32'd0, 32'(wait_count - wait_base));
		got_addr.delete();
		got_data.delete();
		finish_test("index_filter");

		// Download flag leads by one cycle so cart_download lines up with the other inputs
		for (int i = 0; i < 32; i++) begin
			r_reload = 1'($random(seed));
			r_save = 1'($random(seed));
			r_open = 1'($random(seed));
			r_auto = 1'($random(seed));
			r_dl = 1'($random(seed));
			r_mount = 1'($random(seed));
			@(posedge clk_1x);
			ioctl_index <= 8'd1;
			ioctl_download <= r_dl;
			@(posedge clk_1x);
			osd_reload <= r_reload;
			osd_save <= r_save;
			osd_open <= r_open;
			autosave_off <= r_auto;
			img_mounted <= r_mount;
			@(posedge clk_1x);
			@(negedge clk_1x);
			check_value("bk_load", 32'(r_reload | (r_dl & r_mount)), 32'(bk_load));
			check_value("bk_save", 32'(r_save | (r_open & ~r_auto)), 32'(bk_save));
		end
		@(posedge clk_1x);
		osd_reload <= 1'b0;
		osd_save <= 1'b0;
		osd_open <= 1'b0;
		autosave_off <= 1'b0;
		img_mounted <= 1'b0;
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_1x);
		finish_test("load_save_requests");

		pulse_mount(1'b0, 32'h0001_0000 | 32'($random(seed) & 32'hffff));
		check_value("use_img writable mount", 32'd1, 32'(use_img));
		start_download(8'd1);
		@(negedge clk_1x);
		check_value("use_img new download", 32'd0, 32'(use_img));
		stop_download();
		pulse_mount(1'b1, 32'h0000_2000);
		check_value("use_img read-only mount", 32'd0, 32'(use_img));
		pulse_mount(1'b0, 32'd0);
		check_value("use_img empty mount", 32'd0, 32'(use_img));
		finish_test("image_use");

		for (int v = 0; v < 6; v++) begin
			@(posedge clk_1x);
			save_type <= n64_loader_pkg::save_type_e'(v);
			@(posedge clk_1x);
			@(negedge clk_1x);
			check_value("eeprom_type", expected_eeprom(v), 32'(eeprom_type));
		end
		finish_test("eeprom_decode");

		$display("Summary: %0d tests run, %0d with errors, %0d check errors",
			tests_run, tests_bad, total_errors);
		if (tests_bad == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
